// ==== logic/bus_line_driver.sv ====
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module bus_line_driver
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   bus_active,
    input  eeprom_pkg::cond_req_t  cond_req,
    output logic                   cond_done,
    input  logic                   sda_low,
    output eeprom_pkg::line_tick_t tick,
    output logic                   sda_in,
    output logic                   scl,
    inout  wire                    sda
);

    localparam int HALF = `EE_SCL_HALF;
    localparam int MID = (HALF - 1) / 2;
    localparam int CW = $clog2(HALF);

    typedef enum logic [2:0]
    {
        C_IDLE,
        C_START,
        C_HOLD,
        C_STOP_LOW,
        C_STOP_HIGH
    } cond_st_t;

    cond_st_t      cst;
    logic [CW-1:0] cnt;
    logic          run;   // first cycle after bus_active rises is spent here
    logic          scl_q;
    logic          cond_low;
    logic          sda_meta;
    logic          sda_sync;

    always_ff @(posedge CLK)
    begin
        if (RESET || !bus_active)
        begin
            run <= 1'b0;
            cnt <= '0;
            scl_q <= 1'b1;   // idle bus keeps scl high
        end
        else
        begin
            run <= 1'b1;
            if (run)
            begin
                if (cnt == CW'(HALF - 1))
                begin
                    cnt <= '0;
                    scl_q <= !scl_q;
                end
                else
                    cnt <= cnt + 1'b1;
            end
        end
    end

    assign tick.scl_rise = run && scl_q && (cnt == CW'(MID));
    assign tick.scl_fall = run && !scl_q && (cnt == CW'(MID));

    assign cond_done = tick.scl_rise && (cst == C_START || cst == C_STOP_HIGH);

    // start: pull sda low mid-high, hand over at the next low phase
    // stop: pull low mid-low, let go mid-high
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cst <= C_IDLE;
            cond_low <= 1'b0;
        end
        else
        begin
            case (cst)
                C_IDLE:
                begin
                    if (cond_req.start_cond)
                        cst <= C_START;
                    else if (cond_req.stop_cond)
                        cst <= C_STOP_LOW;
                end
                C_START:
                begin
                    if (tick.scl_rise)
                    begin
                        cond_low <= 1'b1;
                        cst <= C_HOLD;
                    end
                end
                C_HOLD:
                begin
                    if (tick.scl_fall)   // shifter drives bit 7 here
                    begin
                        cond_low <= 1'b0;
                        cst <= C_IDLE;
                    end
                end
                C_STOP_LOW:
                begin
                    if (tick.scl_fall)
                    begin
                        cond_low <= 1'b1;
                        cst <= C_STOP_HIGH;
                    end
                end
                C_STOP_HIGH:
                begin
                    if (tick.scl_rise)
                    begin
                        cond_low <= 1'b0;
                        cst <= C_IDLE;
                    end
                end
                default:
                    cst <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            sda_meta <= 1'b1;
            sda_sync <= 1'b1;
        end
        else
        begin
            sda_meta <= sda;
            sda_sync <= sda_meta;
        end
    end

    assign sda_in = sda_sync;
    assign scl = scl_q;
    assign sda = (sda_low || cond_low) ? 1'b0 : 1'bz;   // open drain

endmodule

// ==== logic/byte_shifter.sv ====
`timescale 1ns/10ps

module byte_shifter
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  eeprom_pkg::line_tick_t tick,
    input  logic                   sda_in,
    input  eeprom_pkg::byte_req_t  req,
    output eeprom_pkg::byte_rsp_t  rsp,
    output logic                   sda_low
);

    logic       busy;
    logic [3:0] bit_cnt;   // scl_fall ticks seen since start
    logic       rcv;
    logic       mnack;
    logic [7:0] shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy <= 1'b0;
            bit_cnt <= '0;
            sda_low <= 1'b0;
        end
        else if (!busy)
        begin
            if (req.start)
            begin
                busy <= 1'b1;
                bit_cnt <= '0;
            end
            else if (tick.scl_fall)
                sda_low <= 1'b0;   // let go of the ninth bit
        end
        else if (tick.scl_fall)
        begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt < 4'd8)
                sda_low <= !rcv && !shreg[7];
            else
                sda_low <= rcv && !mnack;   // released for the slave ack on tx
        end
        else if (tick.scl_rise && bit_cnt == 4'd9)
            busy <= 1'b0;
    end

    // tx shifts its own bits back in, so after eight rises shreg holds the bus byte
    always_ff @(posedge CLK)
    begin
        if (!busy && req.start)
        begin
            rcv <= req.receive;
            mnack <= req.master_nack;
            shreg <= req.tx.raw;
        end
        else if (busy && tick.scl_rise && bit_cnt != 4'd0 && bit_cnt != 4'd9)
            shreg <= {shreg[6:0], sda_in};
    end

    assign rsp.done = busy && tick.scl_rise && (bit_cnt == 4'd9);
    assign rsp.rx = shreg;
    assign rsp.ack_bit = sda_in;   // only meaningful with done

endmodule

// ==== logic/eeprom_ctrl.sv ====
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module eeprom_ctrl
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    wr,
    input  logic                    rd,
    input  logic [`EE_ADDR_W-1:0]   addr,
    input  logic [7:0]              wdata,
    output logic                    ack,
    output logic                    nack,
    output logic [7:0]              rdata,
    output eeprom_pkg::cond_req_t   cond_req,
    input  logic                    cond_done,
    output eeprom_pkg::byte_req_t   byte_req,
    input  eeprom_pkg::byte_rsp_t   byte_rsp,
    output logic                    bus_active
);

    typedef enum logic [3:0]
    {
        S_IDLE,
        S_START,
        S_SEL_WR,
        S_ADDR,
        S_DATA_WR,
        S_RESTART,
        S_SEL_RD,
        S_DATA_RD,
        S_STOP,
        S_ACK
    } state_t;

    state_t     st;
    logic       is_read;
    logic       nack_acc;   // any slave nack in this transfer
    logic [7:0] rx_q;

    function automatic eeprom_pkg::byte_req_t send_sel(input logic [2:0] block,
                                                       input logic rnw);
        eeprom_pkg::byte_req_t r;
        r.start = 1'b1;
        r.receive = 1'b0;
        r.master_nack = 1'b0;
        r.tx.sel.dev_type = `EE_DEV_TYPE;
        r.tx.sel.block = block;
        r.tx.sel.rnw = rnw;
        return r;
    endfunction

    function automatic eeprom_pkg::byte_req_t send_raw(input logic [7:0] value,
                                                       input logic receive);
        eeprom_pkg::byte_req_t r;
        r.start = 1'b1;
        r.receive = receive;
        r.master_nack = receive;   // single byte read ends with nack
        r.tx.raw = value;
        return r;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            st <= S_IDLE;
            is_read <= 1'b0;
            nack_acc <= 1'b0;
            bus_active <= 1'b0;
            ack <= 1'b0;
            nack <= 1'b0;
            rdata <= '0;
            cond_req <= '0;
            byte_req <= '0;
        end
        else
        begin
            cond_req <= '0;
            byte_req.start <= 1'b0;
            ack <= 1'b0;
            case (st)
                S_IDLE:
                begin
                    if (wr || rd)
                    begin
                        is_read <= !wr;   // wr wins
                        nack_acc <= 1'b0;
                        bus_active <= 1'b1;
                        cond_req.start_cond <= 1'b1;
                        st <= S_START;
                    end
                end
                S_START:
                begin
                    if (cond_done)
                    begin
                        byte_req <= send_sel(addr[`EE_ADDR_W-1:8], 1'b0);
                        st <= S_SEL_WR;
                    end
                end
                S_SEL_WR:
                begin
                    if (byte_rsp.done)
                    begin
                        nack_acc <= nack_acc | byte_rsp.ack_bit;
                        byte_req <= send_raw(addr[7:0], 1'b0);
                        st <= S_ADDR;
                    end
                end
                S_ADDR:
                begin
                    if (byte_rsp.done)
                    begin
                        nack_acc <= nack_acc | byte_rsp.ack_bit;
                        if (is_read)
                        begin
                            cond_req.start_cond <= 1'b1;
                            st <= S_RESTART;
                        end
                        else
                        begin
                            byte_req <= send_raw(wdata, 1'b0);
                            st <= S_DATA_WR;
                        end
                    end
                end
                S_DATA_WR:
                begin
                    if (byte_rsp.done)
                    begin
                        nack_acc <= nack_acc | byte_rsp.ack_bit;
                        cond_req.stop_cond <= 1'b1;
                        st <= S_STOP;
                    end
                end
                S_RESTART:
                begin
                    if (cond_done)
                    begin
                        byte_req <= send_sel(addr[`EE_ADDR_W-1:8], 1'b1);
                        st <= S_SEL_RD;
                    end
                end
                S_SEL_RD:
                begin
                    if (byte_rsp.done)
                    begin
                        nack_acc <= nack_acc | byte_rsp.ack_bit;
                        byte_req <= send_raw(8'h00, 1'b1);
                        st <= S_DATA_RD;
                    end
                end
                S_DATA_RD:
                begin
                    if (byte_rsp.done)   // ninth bit is our own nack
                    begin
                        cond_req.stop_cond <= 1'b1;
                        st <= S_STOP;
                    end
                end
                S_STOP:
                begin
                    if (cond_done)
                    begin
                        bus_active <= 1'b0;
                        ack <= 1'b1;
                        nack <= nack_acc;
                        if (is_read)
                            rdata <= rx_q;
                        st <= S_ACK;
                    end
                end
                S_ACK:
                    st <= S_IDLE;   // host drops its request here
                default:
                    st <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (st == S_DATA_RD && byte_rsp.done)
            rx_q <= byte_rsp.rx;
    end

endmodule

// ==== logic/eeprom_macros.svh ====
`ifndef EEPROM_MACROS_SVH
`define EEPROM_MACROS_SVH

// clk cycles per half scl period, 2 or more
`define EE_SCL_HALF 4

// device type code in the select byte
`define EE_DEV_TYPE 4'b1010

// host address width, upper three bits pick the block
`define EE_ADDR_W 11

`endif

// ==== logic/eeprom_pkg.sv ====
package eeprom_pkg;

    // strobes in the middle of the scl high and low phases
    typedef struct packed
    {
        logic scl_rise;
        logic scl_fall;
    } line_tick_t;

    typedef struct packed
    {
        logic [3:0] dev_type;
        logic [2:0] block;   // address bits 10:8
        logic       rnw;
    } sel_byte_t;

    // byte going into the shifter
    typedef union packed
    {
        sel_byte_t  sel;
        logic [7:0] raw;
    } eeprom_byte_u;

    typedef struct packed
    {
        logic         start;
        logic         receive;
        logic         master_nack;  // ninth bit sent after a received byte
        eeprom_byte_u tx;
    } byte_req_t;

    typedef struct packed
    {
        logic       done;
        logic [7:0] rx;
        logic       ack_bit;
    } byte_rsp_t;

    typedef struct packed
    {
        logic start_cond;
        logic stop_cond;
    } cond_req_t;

endpackage

// ==== logic/eeprom_wr.sv ====
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module eeprom_wr
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [7:0]            wdata,
    output logic                  ack,
    output logic [7:0]            rdata,
    output logic                  nack,
    output logic                  scl,
    inout  wire                   sda
);

    eeprom_pkg::cond_req_t  cond_req;
    eeprom_pkg::byte_req_t  byte_req;
    eeprom_pkg::byte_rsp_t  byte_rsp;
    eeprom_pkg::line_tick_t tick;
    logic                   cond_done;
    logic                   bus_active;
    logic                   sda_low;
    logic                   sda_in;

    eeprom_ctrl eeprom_ctrl_i
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .ack        (ack),
        .nack       (nack),
        .rdata      (rdata),
        .cond_req   (cond_req),
        .cond_done  (cond_done),
        .byte_req   (byte_req),
        .byte_rsp   (byte_rsp),
        .bus_active (bus_active)
    );

    bus_line_driver bus_line_driver_i
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .bus_active (bus_active),
        .cond_req   (cond_req),
        .cond_done  (cond_done),
        .sda_low    (sda_low),
        .tick       (tick),
        .sda_in     (sda_in),
        .scl        (scl),
        .sda        (sda)
    );

    byte_shifter byte_shifter_i
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .tick    (tick),
        .sda_in  (sda_in),
        .req     (byte_req),
        .rsp     (byte_rsp),
        .sda_low (sda_low)
    );

endmodule

// ==== tb/eeprom_model.sv ====
`timescale 1ns/10ps

module eeprom_model
(
    input  logic scl,
    inout  wire  sda,
    input  logic present
);

    logic [7:0]  mem [0:2047];
    logic        drive_low;
    logic        active;     // between start and stop
    logic        sending;    // slave owns sda for the data bits
    int          slot;       // 0..7 data bits, 8 is the ack bit
    int          byte_idx;
    logic [7:0]  shreg;
    logic [10:0] ptr;
    logic        hit;

    // an absent device never pulls the line
    assign sda = (drive_low && present) ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;
        drive_low = 1'b0;
        active = 1'b0;
        sending = 1'b0;
        slot = -1;
        byte_idx = 0;
        shreg = '0;
        ptr = '0;
        hit = 1'b0;
    end

    task automatic accept_byte();
        if (byte_idx == 0)
        begin
            ptr[10:8] = shreg[3:1];   // block bits
            sending = shreg[0];
            if (shreg[0])
                shreg = mem[ptr];
        end
        else if (byte_idx == 1)
            ptr[7:0] = shreg;
        else
        begin
            mem[ptr] = shreg;
            ptr = ptr + 1'b1;
        end
        byte_idx++;
    endtask

    always @(negedge sda)
    begin
        if (scl === 1'b1)   // start or repeated start
        begin
            active = 1'b1;
            sending = 1'b0;
            drive_low = 1'b0;
            slot = -1;
            byte_idx = 0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)   // stop
        begin
            active = 1'b0;
            sending = 1'b0;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active && slot >= 0 && slot < 8 && !sending)
            shreg[7 - slot] = sda;
        else if (active && slot == 8 && sending && !drive_low)   // not our own select ack
        begin
            if (sda === 1'b0)   // master asks for another byte
            begin
                ptr = ptr + 1'b1;
                shreg = mem[ptr];
            end
            else
                sending = 1'b0;
        end
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            slot = (slot == 8) ? 0 : slot + 1;
            if (slot < 8)
                drive_low = sending && !shreg[7 - slot];
            else if (sending)
                drive_low = 1'b0;   // ninth bit belongs to the master
            else
            begin
                hit = present && (byte_idx != 0 || shreg[7:4] == 4'b1010);
                drive_low = hit;
                if (hit)
                    accept_byte();
            end
        end
    end

endmodule

// ==== tb/eeprom_wr_assertions.sv ====
`timescale 1ns/10ps

module eeprom_wr_assertions
(
    input logic CLK,
    input logic RESET,
    input logic ack,
    input logic scl,
    input logic sda,
    input logic bus_active,
    input logic cond_done
);

    int fail_count = 0;

    ack_single_cycle: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else
        begin
            fail_count++;
            $error("ack stayed high for two cycles");
        end

    // sda moves under a high scl only right after a start or stop edge
    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !$past(cond_done)) |-> (sda == $past(sda)))
        else
        begin
            fail_count++;
            $error("sda changed while scl was high");
        end

    scl_idle_high: assert property (@(posedge CLK) disable iff (RESET) !bus_active |-> scl)
        else
        begin
            fail_count++;
            $error("scl low while the bus is idle");
        end

endmodule

bind eeprom_wr eeprom_wr_assertions eeprom_wr_assertions_i
(
    .CLK        (CLK),
    .RESET      (RESET),
    .ack        (ack),
    .scl        (scl),
    .sda        (sda),
    .bus_active (bus_active),
    .cond_done  (cond_done)
);

// ==== tb/eeprom_wr_tb.sv ====
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module eeprom_wr_tb;

    localparam int ACK_TIMEOUT = 2000;

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic [`EE_ADDR_W-1:0] addr;
    logic [7:0]            wdata;
    logic                  ack;
    logic [7:0]            rdata;
    logic                  nack;
    logic                  scl;
    wire                   sda;
    logic                  present;
    logic [31:0]           lfsr;
    logic [7:0]            shadow [0:2047];   // expected memory contents
    logic [`EE_ADDR_W-1:0] written [$];

    pullup (sda);

    eeprom_wr eeprom_wr_i
    (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata),
        .nack  (nack),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_model eeprom_model_i
    (
        .scl     (scl),
        .sda     (sda),
        .present (present)
    );

    initial
    begin
        CLK = 1'b0;
        forever
            #50 CLK = !CLK;
    end

    // fibonacci, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task stop_on_error();
        $display("Errors found");
        $fatal(1);
    endtask

    always @(eeprom_wr_i.eeprom_wr_assertions_i.fail_count)
    begin
        assert (eeprom_wr_i.eeprom_wr_assertions_i.fail_count == 0)
        else
        begin
            $display("a bus protocol assertion failed");
            stop_on_error();
        end
    end

    task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task remember(input logic [`EE_ADDR_W-1:0] a, input logic [7:0] d);
        shadow[a] = d;
        written.push_back(a);
    endtask

    task run_request(input logic w, input logic r, input logic [`EE_ADDR_W-1:0] a,
                     input logic [7:0] d);
        int waited;
        waited = 0;
        @(posedge CLK);
        wr <= w;
        rd <= r;
        addr <= a;
        wdata <= d;
        @(negedge CLK);
        while (ack !== 1'b1)
        begin
            waited++;
            assert (waited < ACK_TIMEOUT)
            else
            begin
                $display("no ack within %0d cycles of the request", ACK_TIMEOUT);
                stop_on_error();
            end
            @(negedge CLK);
        end
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        @(negedge CLK);
        check_value("ack", ack, 0);   // single pulse
    endtask

    task do_write(input logic [`EE_ADDR_W-1:0] a, input logic [7:0] d, input logic exp_nack);
        run_request(1'b1, 1'b0, a, d);
        check_value("nack", nack, exp_nack);
        if (!exp_nack)
            remember(a, d);
    endtask

    task do_read(input logic [`EE_ADDR_W-1:0] a, input logic [7:0] exp, input logic exp_nack);
        run_request(1'b0, 1'b1, a, 8'h00);
        check_value("nack", nack, exp_nack);
        check_value("rdata", rdata, exp);
    endtask

    task idle_after_reset();
        repeat (8)
        begin
            @(negedge CLK);
            check_value("ack", ack, 0);
            check_value("nack", nack, 0);
            check_value("rdata", rdata, 0);
            check_value("scl", scl, 1);
            check_value("sda", sda, 1);
        end
    endtask

    task write_then_read_back();
        logic [`EE_ADDR_W-1:0] a;
        logic [7:0]            d;
        a = take_bits(`EE_ADDR_W);
        d = take_bits(8);
        do_write(a, d, 1'b0);
        do_read(a, d, 1'b0);
    endtask

    task all_blocks_round_trip();
        logic [`EE_ADDR_W-1:0] a [0:7];
        logic [7:0]            lo;
        int                    k;
        lo = take_bits(8);   // same word offset in every block
        for (int b = 0; b < 8; b++)
        begin
            a[b] = {3'(b), lo};
            do_write(a[b], 8'(take_bits(8)), 1'b0);
        end
        for (int i = 0; i < 8; i++)
        begin
            k = (i * 5 + 3) % 8;   // 3 0 5 2 7 4 1 6
            do_read(a[k], shadow[a[k]], 1'b0);
        end
    endtask

    task absent_device_nacks();
        logic [`EE_ADDR_W-1:0] a;
        a = written[0];
        @(posedge CLK);
        present <= 1'b0;
        do_write(a, 8'(take_bits(8)), 1'b1);
        do_read(a, 8'hff, 1'b1);   // released line reads as ones
        @(posedge CLK);
        present <= 1'b1;
        do_read(a, shadow[a], 1'b0);
    endtask

    task wr_and_rd_together();
        logic [`EE_ADDR_W-1:0] a;
        logic [7:0]            d;
        logic [7:0]            last;
        a = take_bits(`EE_ADDR_W);
        d = take_bits(8);
        last = rdata;
        run_request(1'b1, 1'b1, a, d);
        check_value("nack", nack, 0);
        check_value("rdata", rdata, last);   // unchanged, so no read happened
        remember(a, d);
        foreach (written[i])
            do_read(written[i], shadow[written[i]], 1'b0);
    endtask

    initial
    begin
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wdata = '0;
        present = 1'b1;
        lfsr = 32'h525e_187e;
        repeat (16)
            @(posedge CLK);
        RESET <= 1'b0;
        idle_after_reset();
        write_then_read_back();
        all_blocks_round_trip();
        absent_device_nacks();
        wr_and_rd_together();
        $display("No errors");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/eeprom_pkg.sv
logic/bus_line_driver.sv
logic/byte_shifter.sv
logic/eeprom_ctrl.sv
logic/eeprom_wr.sv
tb/eeprom_model.sv
tb/eeprom_wr_assertions.sv
tb/eeprom_wr_tb.sv
